// File: design/rvTypesPkg.sv
/*
 * RV32 architectural types
 * Vector widths for integer words, register indices, CSR addresses and the
 * default floating-point register width
 */

package rvTypesPkg;

    // Integer register value, program counter and instruction word
    localparam int xlen = 32;

    // Register index width for both the integer and the FP file
    localparam int regAddrWidth = 5;

    localparam int csrAddrWidth = 12;

    // Single precision by default; 64 gives double precision
    localparam int flenDefault = 32;

    typedef logic [xlen-1:0] wordT;

    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef logic [csrAddrWidth-1:0] csrAddrT;

endpackage

// File: design/pipeTypesPkg.sv
/*
 * Pipeline field types
 * Per-instruction fields carried between stages and the bit positions of the
 * operand fields inside an RV32 instruction word
 */

package pipeTypesPkg;

    // Decode output, carried unchanged by register read
    localparam int ctrlWidth = 8;

    // The trap cause sits in the low bits, the trap-valid bit above it
    localparam int trapCauseWidth = 4;

    typedef logic [ctrlWidth-1:0] ctrlT;

    typedef logic [trapCauseWidth:0] trapT;

    // Source register fields of the standard and R4 formats
    localparam int rs1Msb = 19;
    localparam int rs1Lsb = 15;

    localparam int rs2Msb = 24;
    localparam int rs2Lsb = 20;

    // Third source, used only by the fused multiply-add group
    localparam int rs3Msb = 31;
    localparam int rs3Lsb = 27;

    // CSR address of the SYSTEM opcode
    localparam int csrMsb = 31;
    localparam int csrLsb = 20;

endpackage

// File: design/intRegFile.sv
/*
 * Integer register file
 * Thirty-two words with two combinational reads and one clocked write;
 * x0 ignores writes and always reads as zero
 */

`timescale 1ns/1ns

module intRegFile (
    input  logic               clk,
    input  logic               arstN,
    input  rvTypesPkg::regAddrT rdAddr1,
    input  rvTypesPkg::regAddrT rdAddr2,
    output rvTypesPkg::wordT    rdData1,
    output rvTypesPkg::wordT    rdData2,
    input  logic               wrEn,
    input  rvTypesPkg::regAddrT wrAddr,
    input  rvTypesPkg::wordT    wrData
);

    rvTypesPkg::wordT regs [32];

    // Writes land at the edge, so a read in the same cycle still sees the
    // old contents
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 is cleared by reset and never written, so it always reads zero
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

endmodule

// File: design/fpRegFile.sv
/*
 * Floating-point register file
 * Thirty-two FLEN-bit entries with three combinational reads for fused
 * multiply-add operands and one clocked write
 */

`timescale 1ns/1ns

module fpRegFile #(
    parameter int FLEN = rvTypesPkg::flenDefault
) (
    input  logic                clk,
    input  logic                arstN,
    input  rvTypesPkg::regAddrT rdAddr1,
    input  rvTypesPkg::regAddrT rdAddr2,
    input  rvTypesPkg::regAddrT rdAddr3,
    output logic [FLEN-1:0]     rdData1,
    output logic [FLEN-1:0]     rdData2,
    output logic [FLEN-1:0]     rdData3,
    input  logic                wrEn,
    input  rvTypesPkg::regAddrT wrAddr,
    input  logic [FLEN-1:0]     wrData
);

    logic [FLEN-1:0] regs [32];

    // Unlike the integer file, f0 is an ordinary register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // No bypass from the write port
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];
    assign rdData3 = regs[rdAddr3];

endmodule

// File: design/regReadStage.sv
/*
 * Register read stage
 * Slices operand and CSR addresses from the instruction, reads both register
 * files and registers the operands with the decode fields for execute
 */

`timescale 1ns/1ns

module regReadStage #(
    parameter int FLEN = rvTypesPkg::flenDefault
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    rrStall,
    input  logic                    flush,

    input  logic                    inValid,
    input  rvTypesPkg::wordT        inPc,
    input  rvTypesPkg::wordT        inInsn,
    input  pipeTypesPkg::ctrlT      inCtrl,
    input  pipeTypesPkg::trapT      inTrap,

    output rvTypesPkg::regAddrT     intRdAddr1,
    output rvTypesPkg::regAddrT     intRdAddr2,
    input  rvTypesPkg::wordT        intRdData1,
    input  rvTypesPkg::wordT        intRdData2,

    output rvTypesPkg::regAddrT     fpRdAddr1,
    output rvTypesPkg::regAddrT     fpRdAddr2,
    output rvTypesPkg::regAddrT     fpRdAddr3,
    input  logic [FLEN-1:0]         fpRdData1,
    input  logic [FLEN-1:0]         fpRdData2,
    input  logic [FLEN-1:0]         fpRdData3,

    output logic                    outValid,
    output rvTypesPkg::wordT        outPc,
    output rvTypesPkg::wordT        outInsn,
    output pipeTypesPkg::ctrlT      outCtrl,
    output rvTypesPkg::csrAddrT     outCsrAddr,
    output pipeTypesPkg::trapT      outTrap,
    output rvTypesPkg::wordT        outIntSrc1,
    output rvTypesPkg::wordT        outIntSrc2,
    output logic [FLEN-1:0]         outFpSrc1,
    output logic [FLEN-1:0]         outFpSrc2,
    output logic [FLEN-1:0]         outFpSrc3
);

    rvTypesPkg::regAddrT rs1;
    rvTypesPkg::regAddrT rs2;
    rvTypesPkg::regAddrT rs3;
    rvTypesPkg::csrAddrT csrAddr;

    // Fields sit at fixed positions, so they are sliced whatever the opcode;
    // execute ignores the ones its instruction does not use
    assign rs1     = inInsn[pipeTypesPkg::rs1Msb:pipeTypesPkg::rs1Lsb];
    assign rs2     = inInsn[pipeTypesPkg::rs2Msb:pipeTypesPkg::rs2Lsb];
    assign rs3     = inInsn[pipeTypesPkg::rs3Msb:pipeTypesPkg::rs3Lsb];
    assign csrAddr = inInsn[pipeTypesPkg::csrMsb:pipeTypesPkg::csrLsb];

    assign intRdAddr1 = rs1;
    assign intRdAddr2 = rs2;
    assign fpRdAddr1  = rs1;
    assign fpRdAddr2  = rs2;
    assign fpRdAddr3  = rs3;

    // Flush wins over stall; a stalled stage simply keeps its register, and
    // the instruction on the inputs waits in decode
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid   <= 1'b0;
            outPc      <= '0;
            outInsn    <= '0;
            outCtrl    <= '0;
            outCsrAddr <= '0;
            outTrap    <= '0;
            outIntSrc1 <= '0;
            outIntSrc2 <= '0;
            outFpSrc1  <= '0;
            outFpSrc2  <= '0;
            outFpSrc3  <= '0;
        end else if (flush) begin
            outValid   <= 1'b0;
            outPc      <= '0;
            outInsn    <= '0;
            outCtrl    <= '0;
            outCsrAddr <= '0;
            outTrap    <= '0;
            outIntSrc1 <= '0;
            outIntSrc2 <= '0;
            outFpSrc1  <= '0;
            outFpSrc2  <= '0;
            outFpSrc3  <= '0;
        end else if (!rrStall) begin
            outValid   <= inValid;
            outPc      <= inPc;
            outInsn    <= inInsn;
            outCtrl    <= inCtrl;
            outCsrAddr <= csrAddr;
            outTrap    <= inTrap;
            outIntSrc1 <= intRdData1;
            outIntSrc2 <= intRdData2;
            outFpSrc1  <= fpRdData1;
            outFpSrc2  <= fpRdData2;
            outFpSrc3  <= fpRdData3;
        end
    end

endmodule

// File: design/regReadUnit.sv
/*
 * Register read unit
 * Joins the register read stage with the integer and FP register files
 */

`timescale 1ns/1ns

module regReadUnit #(
    parameter int FLEN = rvTypesPkg::flenDefault
) (
    input  logic                clk,
    input  logic                arstN,

    input  logic                inValid,
    input  rvTypesPkg::wordT    inPc,
    input  rvTypesPkg::wordT    inInsn,
    input  pipeTypesPkg::ctrlT  inCtrl,
    input  pipeTypesPkg::trapT  inTrap,

    input  logic                rrStall,
    input  logic                flush,

    input  logic                intWrEn,
    input  rvTypesPkg::regAddrT intWrAddr,
    input  rvTypesPkg::wordT    intWrData,
    input  logic                fpWrEn,
    input  rvTypesPkg::regAddrT fpWrAddr,
    input  logic [FLEN-1:0]     fpWrData,

    output logic                outValid,
    output rvTypesPkg::wordT    outPc,
    output rvTypesPkg::wordT    outInsn,
    output pipeTypesPkg::ctrlT  outCtrl,
    output rvTypesPkg::csrAddrT outCsrAddr,
    output pipeTypesPkg::trapT  outTrap,
    output rvTypesPkg::wordT    outIntSrc1,
    output rvTypesPkg::wordT    outIntSrc2,
    output logic [FLEN-1:0]     outFpSrc1,
    output logic [FLEN-1:0]     outFpSrc2,
    output logic [FLEN-1:0]     outFpSrc3
);

    rvTypesPkg::regAddrT intRdAddr1;
    rvTypesPkg::regAddrT intRdAddr2;
    rvTypesPkg::wordT    intRdData1;
    rvTypesPkg::wordT    intRdData2;

    rvTypesPkg::regAddrT fpRdAddr1;
    rvTypesPkg::regAddrT fpRdAddr2;
    rvTypesPkg::regAddrT fpRdAddr3;
    logic [FLEN-1:0]     fpRdData1;
    logic [FLEN-1:0]     fpRdData2;
    logic [FLEN-1:0]     fpRdData3;

    regReadStage #(
        .FLEN(FLEN)
    ) stage0 (
        .clk        (clk),
        .arstN      (arstN),
        .rrStall    (rrStall),
        .flush      (flush),
        .inValid    (inValid),
        .inPc       (inPc),
        .inInsn     (inInsn),
        .inCtrl     (inCtrl),
        .inTrap     (inTrap),
        .intRdAddr1 (intRdAddr1),
        .intRdAddr2 (intRdAddr2),
        .intRdData1 (intRdData1),
        .intRdData2 (intRdData2),
        .fpRdAddr1  (fpRdAddr1),
        .fpRdAddr2  (fpRdAddr2),
        .fpRdAddr3  (fpRdAddr3),
        .fpRdData1  (fpRdData1),
        .fpRdData2  (fpRdData2),
        .fpRdData3  (fpRdData3),
        .outValid   (outValid),
        .outPc      (outPc),
        .outInsn    (outInsn),
        .outCtrl    (outCtrl),
        .outCsrAddr (outCsrAddr),
        .outTrap    (outTrap),
        .outIntSrc1 (outIntSrc1),
        .outIntSrc2 (outIntSrc2),
        .outFpSrc1  (outFpSrc1),
        .outFpSrc2  (outFpSrc2),
        .outFpSrc3  (outFpSrc3)
    );

    intRegFile intRf0 (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddr1 (intRdAddr1),
        .rdAddr2 (intRdAddr2),
        .rdData1 (intRdData1),
        .rdData2 (intRdData2),
        .wrEn    (intWrEn),
        .wrAddr  (intWrAddr),
        .wrData  (intWrData)
    );

    fpRegFile #(
        .FLEN(FLEN)
    ) fpRf0 (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddr1 (fpRdAddr1),
        .rdAddr2 (fpRdAddr2),
        .rdAddr3 (fpRdAddr3),
        .rdData1 (fpRdData1),
        .rdData2 (fpRdData2),
        .rdData3 (fpRdData3),
        .wrEn    (fpWrEn),
        .wrAddr  (fpWrAddr),
        .wrData  (fpWrData)
    );

endmodule

// File: dv/regReadUnitTb.sv
/*
 * Register read unit testbench
 * Replays a table of inputs and expected outputs, one row per clock cycle,
 * and checks every output of the unit
 */

`timescale 1ns/1ns

module regReadUnitTb;

    localparam int flen = rvTypesPkg::flenDefault;
    localparam int timeoutCycles = 1000;

    logic                clk;
    logic                arstN;
    logic                inValid;
    rvTypesPkg::wordT    inPc;
    rvTypesPkg::wordT    inInsn;
    pipeTypesPkg::ctrlT  inCtrl;
    pipeTypesPkg::trapT  inTrap;
    logic                rrStall;
    logic                flush;
    logic                intWrEn;
    rvTypesPkg::regAddrT intWrAddr;
    rvTypesPkg::wordT    intWrData;
    logic                fpWrEn;
    rvTypesPkg::regAddrT fpWrAddr;
    logic [flen-1:0]     fpWrData;

    logic                outValid;
    rvTypesPkg::wordT    outPc;
    rvTypesPkg::wordT    outInsn;
    pipeTypesPkg::ctrlT  outCtrl;
    rvTypesPkg::csrAddrT outCsrAddr;
    pipeTypesPkg::trapT  outTrap;
    rvTypesPkg::wordT    outIntSrc1;
    rvTypesPkg::wordT    outIntSrc2;
    logic [flen-1:0]     outFpSrc1;
    logic [flen-1:0]     outFpSrc2;
    logic [flen-1:0]     outFpSrc3;

    // Expected outputs of the current row, valid one cycle after its inputs
    logic                rowChk;
    logic                expValid;
    rvTypesPkg::wordT    expPc;
    rvTypesPkg::wordT    expInsn;
    pipeTypesPkg::ctrlT  expCtrl;
    rvTypesPkg::csrAddrT expCsr;
    pipeTypesPkg::trapT  expTrap;
    rvTypesPkg::wordT    expInt1;
    rvTypesPkg::wordT    expInt2;
    logic [flen-1:0]     expFp1;
    logic [flen-1:0]     expFp2;
    logic [flen-1:0]     expFp3;

    int rowNum;

    regReadUnit dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .inPc       (inPc),
        .inInsn     (inInsn),
        .inCtrl     (inCtrl),
        .inTrap     (inTrap),
        .rrStall    (rrStall),
        .flush      (flush),
        .intWrEn    (intWrEn),
        .intWrAddr  (intWrAddr),
        .intWrData  (intWrData),
        .fpWrEn     (fpWrEn),
        .fpWrAddr   (fpWrAddr),
        .fpWrData   (fpWrData),
        .outValid   (outValid),
        .outPc      (outPc),
        .outInsn    (outInsn),
        .outCtrl    (outCtrl),
        .outCsrAddr (outCsrAddr),
        .outTrap    (outTrap),
        .outIntSrc1 (outIntSrc1),
        .outIntSrc2 (outIntSrc2),
        .outFpSrc1  (outFpSrc1),
        .outFpSrc2  (outFpSrc2),
        .outFpSrc3  (outFpSrc3)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkField(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            reportFailure($sformatf("FAILED %s row %0d expected %0h actual %0h",
                                    name, rowNum, expected, actual));
        end
    endtask

    task automatic checkOutputs();
        checkField("outValid", 64'(expValid), 64'(outValid));
        checkField("outPc", 64'(expPc), 64'(outPc));
        checkField("outInsn", 64'(expInsn), 64'(outInsn));
        checkField("outCtrl", 64'(expCtrl), 64'(outCtrl));
        checkField("outCsrAddr", 64'(expCsr), 64'(outCsrAddr));
        checkField("outTrap", 64'(expTrap), 64'(outTrap));
        checkField("outIntSrc1", 64'(expInt1), 64'(outIntSrc1));
        checkField("outIntSrc2", 64'(expInt2), 64'(outIntSrc2));
        checkField("outFpSrc1", 64'(expFp1), 64'(outFpSrc1));
        checkField("outFpSrc2", 64'(expFp2), 64'(outFpSrc2));
        checkField("outFpSrc3", 64'(expFp3), 64'(outFpSrc3));
    endtask

    initial begin
        int    fd;
        int    fields;
        int    cycles;
        bit    endOfData;
        string line;

        arstN     = 1'b0;
        inValid   = 1'b0;
        inPc      = '0;
        inInsn    = '0;
        inCtrl    = '0;
        inTrap    = '0;
        rrStall   = 1'b0;
        flush     = 1'b0;
        intWrEn   = 1'b0;
        intWrAddr = '0;
        intWrData = '0;
        fpWrEn    = 1'b0;
        fpWrAddr  = '0;
        fpWrData  = '0;
        rowNum    = 0;

        // While reset is low every output must read zero
        expValid = 1'b0;
        expPc    = '0;
        expInsn  = '0;
        expCtrl  = '0;
        expCsr   = '0;
        expTrap  = '0;
        expInt1  = '0;
        expInt2  = '0;
        expFp1   = '0;
        expFp2   = '0;
        expFp3   = '0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            checkOutputs();
        end
        arstN = 1'b1;

        fd = $fopen("dv/regReadInput.txt", "r");
        if (fd == 0) begin
            reportFailure("Could not open the data file dv/regReadInput.txt");
        end

        // Comment and blank lines scan no fields and cost no cycle
        cycles    = 0;
        endOfData = 1'b0;
        while (!endOfData && (cycles < timeoutCycles)) begin
            if ($fgets(line, fd) == 0) begin
                endOfData = 1'b1;
            end else begin
                fields = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    rowChk, inValid, inPc, inInsn, inCtrl, inTrap, rrStall, flush,
                    intWrEn, intWrAddr, intWrData, fpWrEn, fpWrAddr, fpWrData,
                    expValid, expPc, expInsn, expCtrl, expCsr, expTrap,
                    expInt1, expInt2, expFp1, expFp2, expFp3);
                if (fields == 25) begin
                    rowNum = rowNum + 1;
                    @(posedge clk);
                    @(negedge clk);
                    cycles = cycles + 1;
                    if (rowChk) begin
                        checkOutputs();
                    end
                end else if (fields > 0) begin
                    reportFailure($sformatf("Data row %0d has only %0d of 25 columns",
                                            rowNum + 1, fields));
                end
            end
        end
        $fclose(fd);

        if (endOfData) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            reportFailure($sformatf("Timeout after %0d cycles before the end of the data file",
                                    timeoutCycles));
        end
    end

endmodule

// File: dv/regReadInput.txt
// chk valid pc insn ctrl trap stall flush intWe intWa intWd fpWe fpWa fpWd, then expected
// one cycle later: valid pc insn ctrl csr trap int1 int2 fp1 fp2 fp3 (all hex)

// Right after reset, idle then a read of unwritten registers
1 0 0 00000000 00 00 0 0 0 0 0 0 0 0   0 0 00000000 00 000 00 0 0 0 0 0
1 1 100 18208053 a5 00 0 0 0 0 0 0 0 0   1 100 18208053 a5 182 00 0 0 0 0 0

// Writes followed by reads of x1 x2 and f1 f2 f3, same-cycle reads see old values
1 1 104 18208053 3c 13 0 0 1 1 1001 1 3 f003   1 104 18208053 3c 182 13 0 0 0 0 0
1 1 108 18208053 01 00 0 0 1 2 2002 1 1 f001   1 108 18208053 01 182 00 1001 0 0 0 f003
1 1 10c 18208053 02 00 0 0 0 0 0 1 2 f002   1 10c 18208053 02 182 00 1001 2002 f001 0 f003
1 1 110 10118053 22 00 0 0 0 0 0 0 0 0   1 110 10118053 22 101 00 0 1001 f003 f001 f002

// Register zero, ignored in the integer file but ordinary in the FP file
1 1 114 00000053 44 00 0 0 1 0 dead 1 0 beef   1 114 00000053 44 000 00 0 0 0 0 0
1 1 118 00000053 45 00 0 0 0 0 0 0 0 0   1 118 00000053 45 000 00 0 0 beef beef beef
1 1 11c 00100053 55 1f 0 0 0 0 0 0 0 0   1 11c 00100053 55 001 1f 0 1001 beef f001 beef

// Stall holds the outputs while inputs change and writes land
1 1 120 18208053 66 00 0 0 0 0 0 0 0 0   1 120 18208053 66 182 00 1001 2002 f001 f002 f003
1 1 124 10118053 77 00 1 0 1 1 1aa1 1 1 faa1   1 120 18208053 66 182 00 1001 2002 f001 f002 f003
1 0 128 00100053 88 00 1 0 1 2 2bb2 1 2 fbb2   1 120 18208053 66 182 00 1001 2002 f001 f002 f003
1 1 12c 18208053 99 12 1 0 0 0 0 0 0 0   1 120 18208053 66 182 00 1001 2002 f001 f002 f003
1 1 12c 18208053 99 12 0 0 0 0 0 0 0 0   1 12c 18208053 99 182 12 1aa1 2bb2 faa1 fbb2 f003

// Flush alone, then flush together with stall
1 1 130 10118053 ab 00 0 1 0 0 0 0 0 0   0 0 00000000 00 000 00 0 0 0 0 0
1 1 134 10118053 cd 00 0 0 0 0 0 0 0 0   1 134 10118053 cd 101 00 0 1aa1 f003 faa1 fbb2
1 1 138 18208053 ee 15 1 1 0 0 0 0 0 0   0 0 00000000 00 000 00 0 0 0 0 0
1 1 13c 18208053 ef 00 1 0 0 0 0 0 0 0   0 0 00000000 00 000 00 0 0 0 0 0
1 1 13c 18208053 ef 00 0 0 0 0 0 0 0 0   1 13c 18208053 ef 182 00 1aa1 2bb2 faa1 fbb2 f003

// Idle slots still read the files, then full-width values in x31 and f31
1 0 0 00000000 00 00 0 0 0 0 0 0 0 0   0 0 00000000 00 000 00 0 0 beef beef beef
1 0 0 00000000 00 00 0 0 1 1f cafe0001 1 1f 80000000   0 0 00000000 00 000 00 0 0 beef beef beef
1 1 140 f80f8053 12 1a 0 0 0 0 0 0 0 0   1 140 f80f8053 12 f80 1a cafe0001 0 80000000 beef 80000000

// File: regReadUnit.f
design/rvTypesPkg.sv
design/pipeTypesPkg.sv
design/intRegFile.sv
design/fpRegFile.sv
design/regReadStage.sv
design/regReadUnit.sv
dv/regReadUnitTb.sv

// File: Makefile
# Verilator build and run of the register read unit testbench

VERILATOR ?= verilator
TOP       ?= regReadUnitTb
FILELIST  ?= regReadUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^RESULT: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
